// ==== verilog/mem_subsys_consts.svh ====
`ifndef MEM_SUBSYS_CONSTS_SVH
`define MEM_SUBSYS_CONSTS_SVH

// ######################################################################
// Datapath widths
// ######################################################################

`define XLEN 32
`define REG_ADDR_W 5

// ######################################################################
// Data SRAM geometry
// ######################################################################

`define SRAM_DEPTH_WORDS 256
// log2 of the depth
`define SRAM_ADDR_W 8

`endif

// ==== verilog/mem_subsys_pkg.sv ====
package mem_subsys_pkg;

    // Memory operation carried down the pipe with each instruction
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB   = 4'd1,
        MEM_LH   = 4'd2,
        MEM_LW   = 4'd3,
        MEM_LBU  = 4'd4,
        MEM_LHU  = 4'd5,
        MEM_SB   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SW   = 4'd8
    } mem_op_e;

    // One strobe bit per byte lane of the data word
    typedef logic [3:0] byte_en_t;

    function automatic logic is_load(mem_op_e op);
        return op inside {MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};
    endfunction

    function automatic logic is_store(mem_op_e op);
        return op inside {MEM_SB, MEM_SH, MEM_SW};
    endfunction

endpackage

// ==== verilog/stage_ifs.sv ====
`timescale 1ns/1ps
`include "mem_subsys_consts.svh"

// Memory-request stage to memory stage
interface ms_bus_if
    import mem_subsys_pkg::*;
();
    logic                     valid;
    logic                     allowin;
    mem_op_e                  mem_op;
    logic                     gr_we;
    logic [`REG_ADDR_W-1:0]   dest;
    logic [`XLEN-1:0]         alu_result;
    logic [`XLEN-1:0]         pc;

    modport sender   (output valid, mem_op, gr_we, dest, alu_result, pc, input allowin);
    modport receiver (input valid, mem_op, gr_we, dest, alu_result, pc, output allowin);
endinterface

// Memory stage to writeback
interface wb_bus_if ();
    logic                     valid;
    logic                     allowin;
    logic                     gr_we;
    logic [`REG_ADDR_W-1:0]   dest;
    logic [`XLEN-1:0]         result;
    logic [`XLEN-1:0]         pc;

    modport sender   (output valid, gr_we, dest, result, pc, input allowin);
    modport receiver (input valid, gr_we, dest, result, pc, output allowin);
endinterface

// Data SRAM port, read data returns to the memory stage
interface sram_if
    import mem_subsys_pkg::*;
();
    logic                     en;
    byte_en_t                 we;
    logic [`SRAM_ADDR_W-1:0]  addr;
    logic [`XLEN-1:0]         wdata;
    logic [`XLEN-1:0]         rdata;

    modport requester (output en, we, addr, wdata);
    modport memory    (input en, we, addr, wdata, output rdata);
    modport reader    (input rdata);
endinterface

// ==== verilog/mem_req_stage.sv ====
`timescale 1ns/1ps
`include "mem_subsys_consts.svh"

module mem_req_stage
    import mem_subsys_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    es_valid,
    output logic                    es_allowin,
    input  mem_op_e                 es_mem_op,
    input  logic                    es_gr_we,
    input  logic [`REG_ADDR_W-1:0]  es_dest,
    input  logic [`XLEN-1:0]        es_alu_result,
    input  logic [`XLEN-1:0]        es_store_data,
    input  logic [`XLEN-1:0]        es_pc,
    ms_bus_if.sender                ms,
    sram_if.requester               sram
);

    logic                    valid_r;
    logic                    ready_go;
    logic                    allowin;
    logic                    transfer;
    mem_op_e                 mem_op_r;
    logic                    gr_we_r;
    logic [`REG_ADDR_W-1:0]  dest_r;
    logic [`XLEN-1:0]        alu_result_r;
    logic [`XLEN-1:0]        store_data_r;
    logic [`XLEN-1:0]        pc_r;
    logic [1:0]              byte_off;
    byte_en_t                store_strb;
    logic [`XLEN-1:0]        store_lanes;

    assign ready_go   = 1'b1;
    assign allowin    = !valid_r || ready_go && ms.allowin;
    assign es_allowin = allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_r <= 1'b0;
        end else if (allowin) begin
            valid_r <= es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_valid && allowin) begin
            mem_op_r     <= es_mem_op;
            gr_we_r      <= es_gr_we;
            dest_r       <= es_dest;
            alu_result_r <= es_alu_result;
            store_data_r <= es_store_data;
            pc_r         <= es_pc;
        end
    end

    assign ms.valid      = valid_r && ready_go;
    assign ms.mem_op     = mem_op_r;
    assign ms.gr_we      = gr_we_r;
    assign ms.dest       = dest_r;
    assign ms.alu_result = alu_result_r;
    assign ms.pc         = pc_r;

    // ######################################################################
    // SRAM request issued on the edge the item moves into mem_stage
    // ######################################################################

    assign transfer = ms.valid && ms.allowin;
    assign byte_off = alu_result_r[1:0];

    // Replicate store data into every lane so the strobes pick the live one
    always_comb begin
        case (mem_op_r)
            MEM_SB: begin
                store_strb  = byte_en_t'(4'b0001) << byte_off;
                store_lanes = {(`XLEN/8){store_data_r[7:0]}};
            end
            MEM_SH: begin
                store_strb  = byte_en_t'(4'b0011) << {byte_off[1], 1'b0};
                store_lanes = {(`XLEN/16){store_data_r[15:0]}};
            end
            MEM_SW: begin
                store_strb  = 4'b1111;
                store_lanes = store_data_r;
            end
            default: begin
                store_strb  = 4'b0000;
                store_lanes = store_data_r;
            end
        endcase
    end

    assign sram.en    = transfer && (is_load(mem_op_r) || is_store(mem_op_r));
    assign sram.we    = transfer ? store_strb : 4'b0000;
    assign sram.addr  = alu_result_r[`SRAM_ADDR_W+1:2];
    assign sram.wdata = store_lanes;

    // Half-word accesses need an even address
    a_half_aligned: assert property (@(posedge clk) disable iff (reset)
        sram.en && mem_op_r inside {MEM_LH, MEM_LHU, MEM_SH} |-> byte_off[0] == 1'b0);

    // Word accesses need a word address
    a_word_aligned: assert property (@(posedge clk) disable iff (reset)
        sram.en && mem_op_r inside {MEM_LW, MEM_SW} |-> byte_off == 2'b00);

endmodule

// ==== verilog/data_sram.sv ====
`timescale 1ns/1ps
`include "mem_subsys_consts.svh"

module data_sram (
    input  logic     clk,
    sram_if.memory   sram
);

    logic [`XLEN-1:0] mem [`SRAM_DEPTH_WORDS];
    logic [`XLEN-1:0] rdata_r;

    // ######################################################################
    // Byte-masked write
    // ######################################################################

    always_ff @(posedge clk) begin
        if (sram.en) begin
            for (int i = 0; i < `XLEN/8; i++) begin
                if (sram.we[i]) begin
                    mem[sram.addr][8*i +: 8] <= sram.wdata[8*i +: 8];
                end
            end
        end
    end

    // ######################################################################
    // Synchronous read returns old data on a same-cycle write
    // ######################################################################

    always_ff @(posedge clk) begin
        if (sram.en) begin
            rdata_r <= mem[sram.addr];
        end
    end

    assign sram.rdata = rdata_r;

endmodule

// ==== verilog/mem_stage.sv ====
`timescale 1ns/1ps
`include "mem_subsys_consts.svh"

module mem_stage
    import mem_subsys_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    ms_bus_if.receiver              ms,
    sram_if.reader                  sram,
    wb_bus_if.sender                wb,
    output logic                    fwd_valid,
    output logic [`REG_ADDR_W-1:0]  fwd_dest,
    output logic [`XLEN-1:0]        fwd_result
);

    logic                    ms_valid;
    logic                    ready_go;
    logic                    allowin;
    mem_op_e                 mem_op_r;
    logic                    gr_we_r;
    logic [`REG_ADDR_W-1:0]  dest_r;
    logic [`XLEN-1:0]        alu_result_r;
    logic [`XLEN-1:0]        pc_r;
    logic [7:0]              load_byte;
    logic [15:0]             load_half;
    logic [`XLEN-1:0]        load_data;
    logic [`XLEN-1:0]        final_result;

    assign ready_go   = 1'b1;
    assign allowin    = !ms_valid || ready_go && wb.allowin;
    assign ms.allowin = allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else if (allowin) begin
            ms_valid <= ms.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms.valid && allowin) begin
            mem_op_r     <= ms.mem_op;
            gr_we_r      <= ms.gr_we;
            dest_r       <= ms.dest;
            alu_result_r <= ms.alu_result;
            pc_r         <= ms.pc;
        end
    end

    // ######################################################################
    // Load lane select and extension
    // ######################################################################

    assign load_byte = sram.rdata[{alu_result_r[1:0], 3'b000} +: 8];
    assign load_half = sram.rdata[{alu_result_r[1], 4'b0000} +: 16];

    always_comb begin
        case (mem_op_r)
            MEM_LB:  load_data = {{(`XLEN-8){load_byte[7]}}, load_byte};
            MEM_LBU: load_data = {{(`XLEN-8){1'b0}}, load_byte};
            MEM_LH:  load_data = {{(`XLEN-16){load_half[15]}}, load_half};
            MEM_LHU: load_data = {{(`XLEN-16){1'b0}}, load_half};
            default: load_data = sram.rdata;
        endcase
    end

    assign final_result = is_load(mem_op_r) ? load_data : alu_result_r;

    assign wb.valid  = ms_valid && ready_go;
    assign wb.gr_we  = gr_we_r;
    assign wb.dest   = dest_r;
    assign wb.result = final_result;
    assign wb.pc     = pc_r;

    // Forward path for the decode stage
    assign fwd_valid  = ms_valid && gr_we_r;
    assign fwd_dest   = dest_r;
    assign fwd_result = final_result;

    // A store arriving here must never request a register write
    a_store_no_we: assert property (@(posedge clk) disable iff (reset)
        ms.valid && allowin && is_store(ms.mem_op) |=> ms_valid && !wb.gr_we);

    // Read data from the previous edge must be known for a load
    a_load_rdata: assert property (@(posedge clk) disable iff (reset)
        ms_valid && is_load(mem_op_r) |-> !$isunknown(sram.rdata));

endmodule

// ==== verilog/wb_stage.sv ====
`timescale 1ns/1ps
`include "mem_subsys_consts.svh"

module wb_stage (
    input  logic                    clk,
    input  logic                    reset,
    wb_bus_if.receiver              wb,
    output logic                    wb_valid,
    output logic [`XLEN-1:0]        wb_pc,
    output logic [`REG_ADDR_W-1:0]  wb_dest,
    output logic [`XLEN-1:0]        wb_result,
    input  logic [`REG_ADDR_W-1:0]  rf_raddr,
    output logic [`XLEN-1:0]        rf_rdata
);

    logic                    ws_valid;
    logic                    ready_go;
    logic                    allowin;
    logic                    gr_we_r;
    logic [`REG_ADDR_W-1:0]  dest_r;
    logic [`XLEN-1:0]        result_r;
    logic [`XLEN-1:0]        pc_r;
    logic [`XLEN-1:0]        rf [2**`REG_ADDR_W];

    // Last stage with nothing downstream to wait on
    assign ready_go   = 1'b1;
    assign allowin    = !ws_valid || ready_go;
    assign wb.allowin = allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else if (allowin) begin
            ws_valid <= wb.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wb.valid && allowin) begin
            gr_we_r  <= wb.gr_we;
            dest_r   <= wb.dest;
            result_r <= wb.result;
            pc_r     <= wb.pc;
        end
    end

    assign wb_valid  = ws_valid;
    assign wb_pc     = pc_r;
    assign wb_dest   = dest_r;
    assign wb_result = result_r;

    // ######################################################################
    // Register file with r0 hardwired to zero
    // ######################################################################

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**`REG_ADDR_W; i++) begin
                rf[i] <= '0;
            end
        end else if (ws_valid && ready_go && gr_we_r && dest_r != '0) begin
            rf[dest_r] <= result_r;
        end
    end

    assign rf_rdata = (rf_raddr == '0) ? '0 : rf[rf_raddr];

endmodule

// ==== verilog/mem_subsys_top.sv ====
`timescale 1ns/1ps
`include "mem_subsys_consts.svh"

module mem_subsys_top
    import mem_subsys_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    es_valid,
    output logic                    es_allowin,
    input  mem_op_e                 es_mem_op,
    input  logic                    es_gr_we,
    input  logic [`REG_ADDR_W-1:0]  es_dest,
    input  logic [`XLEN-1:0]        es_alu_result,
    input  logic [`XLEN-1:0]        es_store_data,
    input  logic [`XLEN-1:0]        es_pc,
    output logic                    fwd_valid,
    output logic [`REG_ADDR_W-1:0]  fwd_dest,
    output logic [`XLEN-1:0]        fwd_result,
    output logic                    wb_valid,
    output logic [`XLEN-1:0]        wb_pc,
    output logic [`REG_ADDR_W-1:0]  wb_dest,
    output logic [`XLEN-1:0]        wb_result,
    input  logic [`REG_ADDR_W-1:0]  rf_raddr,
    output logic [`XLEN-1:0]        rf_rdata
);

    ms_bus_if ms_bus ();
    wb_bus_if wb_bus ();
    sram_if   sram_bus ();

    mem_req_stage i_mem_req_stage (
        .clk           (clk),
        .reset         (reset),
        .es_valid      (es_valid),
        .es_allowin    (es_allowin),
        .es_mem_op     (es_mem_op),
        .es_gr_we      (es_gr_we),
        .es_dest       (es_dest),
        .es_alu_result (es_alu_result),
        .es_store_data (es_store_data),
        .es_pc         (es_pc),
        .ms            (ms_bus.sender),
        .sram          (sram_bus.requester)
    );

    data_sram i_data_sram (
        .clk  (clk),
        .sram (sram_bus.memory)
    );

    mem_stage i_mem_stage (
        .clk        (clk),
        .reset      (reset),
        .ms         (ms_bus.receiver),
        .sram       (sram_bus.reader),
        .wb         (wb_bus.sender),
        .fwd_valid  (fwd_valid),
        .fwd_dest   (fwd_dest),
        .fwd_result (fwd_result)
    );

    wb_stage i_wb_stage (
        .clk       (clk),
        .reset     (reset),
        .wb        (wb_bus.receiver),
        .wb_valid  (wb_valid),
        .wb_pc     (wb_pc),
        .wb_dest   (wb_dest),
        .wb_result (wb_result),
        .rf_raddr  (rf_raddr),
        .rf_rdata  (rf_rdata)
    );

endmodule

// ==== verification/mem_subsys_tb.sv ====
`timescale 1ns/1ps
`include "mem_subsys_consts.svh"

module mem_subsys_tb
    import mem_subsys_pkg::*;
();

    typedef struct {
        int                      edge_no;
        logic                    gr_we;
        logic [`REG_ADDR_W-1:0]  dest;
        logic [`XLEN-1:0]        result;
        logic [`XLEN-1:0]        pc;
    } expect_t;

    logic                    clk;
    logic                    reset;
    logic                    es_valid;
    logic                    es_allowin;
    mem_op_e                 es_mem_op;
    logic                    es_gr_we;
    logic [`REG_ADDR_W-1:0]  es_dest;
    logic [`XLEN-1:0]        es_alu_result;
    logic [`XLEN-1:0]        es_store_data;
    logic [`XLEN-1:0]        es_pc;
    logic                    fwd_valid;
    logic [`REG_ADDR_W-1:0]  fwd_dest;
    logic [`XLEN-1:0]        fwd_result;
    logic                    wb_valid;
    logic [`XLEN-1:0]        wb_pc;
    logic [`REG_ADDR_W-1:0]  wb_dest;
    logic [`XLEN-1:0]        wb_result;
    logic [`REG_ADDR_W-1:0]  rf_raddr;
    logic [`XLEN-1:0]        rf_rdata;

    logic [31:0]             lfsr;
    logic [`XLEN-1:0]        ref_mem [`SRAM_DEPTH_WORDS];
    logic [`XLEN-1:0]        ref_rf [2**`REG_ADDR_W];
    logic [`XLEN-1:0]        pool [8];
    logic [`XLEN-1:0]        next_pc;
    expect_t                 fwd_q [$];
    expect_t                 wb_q [$];
    int                      edge_count;
    int                      issued;
    logic                    checking;

    mem_subsys_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        edge_count <= edge_count + 1;
    end

    // ######################################################################
    // Failure reporting and typed compares
    // ######################################################################

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_logic(string name, logic expected, logic actual);
        if (actual !== expected) begin
            fail_run($sformatf("ERR %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_word(string name, logic [`XLEN-1:0] expected, logic [`XLEN-1:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("ERR %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_reg(string name, logic [`REG_ADDR_W-1:0] expected,
                             logic [`REG_ADDR_W-1:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("ERR %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
            val = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    // ######################################################################
    // Reference models
    // ######################################################################

    function automatic logic [`XLEN-1:0] expect_load(logic [`XLEN-1:0] word, mem_op_e op,
                                                     logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = word[16*off[1] +: 16];
        case (op)
            MEM_LB:  return {{24{b[7]}}, b};
            MEM_LBU: return {24'h0, b};
            MEM_LH:  return {{16{h[15]}}, h};
            MEM_LHU: return {16'h0, h};
            default: return word;
        endcase
    endfunction

    task automatic apply_store(logic [`XLEN-1:0] addr, mem_op_e op, logic [`XLEN-1:0] data);
        logic [`SRAM_ADDR_W-1:0] idx;
        idx = addr[`SRAM_ADDR_W+1:2];
        case (op)
            MEM_SB:  ref_mem[idx][8*addr[1:0] +: 8] = data[7:0];
            MEM_SH:  ref_mem[idx][16*addr[1] +: 16] = data[15:0];
            MEM_SW:  ref_mem[idx] = data;
            default: ;
        endcase
    endtask

    task automatic issue_op(mem_op_e op, logic gr_we, logic [`REG_ADDR_W-1:0] dest,
                            logic [`XLEN-1:0] alu, logic [`XLEN-1:0] sdata);
        expect_t e;
        @(negedge clk);
        while (!es_allowin) @(negedge clk);
        es_valid      = 1'b1;
        es_mem_op     = op;
        es_gr_we      = gr_we;
        es_dest       = dest;
        es_alu_result = alu;
        es_store_data = sdata;
        es_pc         = next_pc;
        // Accepted at the coming edge and in mem_stage one edge later
        e.edge_no = edge_count + 2;
        e.gr_we   = gr_we;
        e.dest    = dest;
        e.pc      = next_pc;
        if (op inside {MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU}) begin
            e.result = expect_load(ref_mem[alu[`SRAM_ADDR_W+1:2]], op, alu[1:0]);
        end else begin
            e.result = alu;
        end
        apply_store(alu, op, sdata);
        if (gr_we && dest != '0) begin
            ref_rf[dest] = e.result;
        end
        fwd_q.push_back(e);
        e.edge_no++;
        wb_q.push_back(e);
        next_pc += 4;
        issued++;
    endtask

    task automatic drain();
        @(negedge clk);
        es_valid = 1'b0;
        while (wb_q.size() > 0) @(negedge clk);
        // One more edge for the register file write
        @(negedge clk);
    endtask

    task automatic check_rf(int r);
        @(negedge clk);
        rf_raddr = r[`REG_ADDR_W-1:0];
        #1;
        check_word($sformatf("rf_rdata[%0d]", r), (r == 0) ? '0 : ref_rf[r], rf_rdata);
    endtask

    // Forward and commit ports are sampled mid-cycle
    always @(negedge clk) begin
        if (checking) begin
            if (fwd_q.size() > 0 && fwd_q[0].edge_no == edge_count) begin
                check_logic("fwd_valid", fwd_q[0].gr_we, fwd_valid);
                if (fwd_q[0].gr_we) begin
                    check_reg("fwd_dest", fwd_q[0].dest, fwd_dest);
                    check_word("fwd_result", fwd_q[0].result, fwd_result);
                end
                void'(fwd_q.pop_front());
            end else begin
                check_logic("fwd_valid", 1'b0, fwd_valid);
            end
            if (wb_q.size() > 0 && wb_q[0].edge_no == edge_count) begin
                check_logic("wb_valid", 1'b1, wb_valid);
                check_word("wb_pc", wb_q[0].pc, wb_pc);
                check_reg("wb_dest", wb_q[0].dest, wb_dest);
                check_word("wb_result", wb_q[0].result, wb_result);
                void'(wb_q.pop_front());
            end else begin
                check_logic("wb_valid", 1'b0, wb_valid);
            end
        end
    end

    initial begin
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > 40 * issued + 100) begin
                fail_run($sformatf("Timeout, the run did not finish within %0d cycles", cycles));
            end
        end
    end

    // ######################################################################
    // Directed tests
    // ######################################################################

    task automatic test_reset();
        check_logic("es_allowin", 1'b1, es_allowin);
        check_logic("fwd_valid", 1'b0, fwd_valid);
        check_logic("wb_valid", 1'b0, wb_valid);
        for (int r = 0; r < 32; r += 7) begin
            check_rf(r);
        end
    endtask

    task automatic test_word_rw();
        for (int i = 0; i < 8; i++) begin
            pool[i] = rand_bits(`SRAM_ADDR_W) << 2;
            issue_op(MEM_SW, 1'b0, '0, pool[i], rand_bits(32));
        end
        // First load targets r0 and r0 must stay zero
        for (int i = 0; i < 8; i++) begin
            issue_op(MEM_LW, 1'b1, i[4:0], pool[i], '0);
        end
        drain();
        for (int r = 0; r < 8; r++) begin
            check_rf(r);
        end
    endtask

    task automatic test_sub_word();
        for (int i = 0; i < 4; i++) begin
            issue_op(MEM_SB, 1'b0, '0, pool[i] + rand_bits(2), rand_bits(32));
            issue_op(MEM_SH, 1'b0, '0, pool[i] + (rand_bits(1) << 1), rand_bits(32));
            issue_op(MEM_LW, 1'b1, 5'(8 + i), pool[i], '0);
        end
        drain();
        for (int r = 8; r < 12; r++) begin
            check_rf(r);
        end
    endtask

    task automatic test_load_ext();
        for (int w = 0; w < 2; w++) begin
            for (int off = 0; off < 4; off++) begin
                issue_op(MEM_LB, 1'b1, 5'(12 + off), pool[w] + off, '0);
                issue_op(MEM_LBU, 1'b1, 5'(16 + off), pool[w] + off, '0);
                if (off % 2 == 0) begin
                    issue_op(MEM_LH, 1'b1, 5'(20 + off), pool[w] + off, '0);
                    issue_op(MEM_LHU, 1'b1, 5'(24 + off), pool[w] + off, '0);
                end
            end
        end
        drain();
        for (int r = 12; r < 28; r++) begin
            check_rf(r);
        end
    endtask

    task automatic test_pass_fwd();
        logic [31:0] d;
        for (int i = 0; i < 6; i++) begin
            d = rand_bits(6);
            issue_op(MEM_NONE, d[5], d[4:0], rand_bits(32), '0);
        end
        issue_op(MEM_SW, 1'b0, 5'd28, pool[0], rand_bits(32));
        issue_op(MEM_NONE, 1'b1, 5'd28, rand_bits(32), '0);
        drain();
        check_rf(28);
    endtask

    task automatic test_stream();
        logic [31:0] sel;
        logic [31:0] d;
        logic [31:0] addr;
        mem_op_e     op;
        // Load straight after a store to the same word
        issue_op(MEM_SW, 1'b0, '0, pool[2], rand_bits(32));
        issue_op(MEM_LW, 1'b1, 5'd29, pool[2], '0);
        for (int n = 0; n < 24; n++) begin
            sel = rand_bits(4) % 9;
            op = mem_op_e'(sel[3:0]);
            d = rand_bits(3);
            addr = pool[d[2:0]];
            d = rand_bits(5);
            case (op)
                MEM_LH, MEM_LHU, MEM_SH: addr += rand_bits(1) << 1;
                MEM_LB, MEM_LBU, MEM_SB: addr += rand_bits(2);
                MEM_NONE:                addr = rand_bits(32);
                default:                 ;
            endcase
            issue_op(op, !(op inside {MEM_SB, MEM_SH, MEM_SW}), d[4:0], addr, rand_bits(32));
        end
        drain();
        for (int r = 0; r < 32; r++) begin
            check_rf(r);
        end
    endtask

    initial begin
        lfsr          = 32'h6b70;
        edge_count    = 0;
        issued        = 0;
        checking      = 1'b0;
        next_pc       = 32'h0000_1000;
        reset         = 1'b1;
        es_valid      = 1'b0;
        es_mem_op     = MEM_NONE;
        es_gr_we      = 1'b0;
        es_dest       = '0;
        es_alu_result = '0;
        es_store_data = '0;
        es_pc         = '0;
        rf_raddr      = '0;
        for (int r = 0; r < 32; r++) begin
            ref_rf[r] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        test_reset();
        checking = 1'b1;
        test_word_rw();
        test_sub_word();
        test_load_ext();
        test_pass_fwd();
        test_stream();
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== mem_subsys.f ====
+incdir+verilog
verilog/mem_subsys_pkg.sv
verilog/stage_ifs.sv
verilog/mem_req_stage.sv
verilog/data_sram.sv
verilog/mem_stage.sv
verilog/wb_stage.sv
verilog/mem_subsys_top.sv
verification/mem_subsys_tb.sv

// ==== Bender.yml ====
package:
  name: mem_subsys

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mem_subsys_pkg.sv
      - verilog/stage_ifs.sv
      - verilog/mem_req_stage.sv
      - verilog/data_sram.sv
      - verilog/mem_stage.sv
      - verilog/wb_stage.sv
      - verilog/mem_subsys_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/mem_subsys_tb.sv
